// File: logic/cpl_pkg.sv
// shared widths, field positions and sizing constants for the completion splitter
// the pending entry layout must match the receive side that fills the request FIFO
package cpl_pkg;

  // pending read entry from the request FIFO
  localparam int PND_ENTRY_W   = 57;
  localparam int PND_TAG_LSB   = 0;
  localparam int PND_TAG_W     = 8;
  // address bits 6..2 only, dword aligned
  localparam int PND_ADDR_LSB  = 10;
  localparam int PND_ADDR_W    = 5;
  localparam int PND_REQID_LSB = 16;
  localparam int PND_REQID_W   = 16;
  localparam int PND_DWLEN_LSB = 32;
  localparam int PND_DWLEN_W   = 11;
  localparam int PND_FBE_LSB   = 43;
  localparam int PND_ATTR_LSB  = 47;
  localparam int PND_ATTR_W    = 2;
  localparam int PND_TC_LSB    = 49;
  localparam int PND_TC_W      = 3;
  localparam int PND_LBE_LSB   = 52;
  localparam int BE_W          = 4;

  // completion command word
  localparam int CMD_W         = 99;
  localparam int CMD_LA_LSB    = 0;
  localparam int CMD_LA_W      = 7;
  localparam int CMD_TAG_LSB   = 7;
  localparam int CMD_REQID_LSB = 15;
  localparam int CMD_ONE_BIT   = 68;
  localparam int CMD_BCNT_LSB  = 70;
  localparam int CMD_BCNT_W    = 12;
  localparam int CMD_TC_LSB    = 82;
  localparam int CMD_DWLEN_LSB = 85;
  localparam int CMD_DWLEN_W   = 9;
  localparam int CMD_ATTR_LSB  = 94;

  // byte counting and credit
  localparam int BCNT_W         = 13;
  localparam int CREDIT_W       = 11;
  localparam int CREDIT_WINDOW  = 1024;
  localparam int RCB_BYTES      = 128;
  localparam int MPS_SMALL      = 128;
  localparam int MPS_LARGE      = 256;
  localparam int BEAT_BYTES     = 8;
  localparam int CMD_FIFO_LIMIT = 8;

endpackage

// File: logic/cpl_split_ctrl.sv
// splits one pending read into RCB, max-payload and last completions
// flush and unsupported-size reads are not handled; the request FIFO is non-show-ahead
`timescale 1ns/1ps

module cpl_split_ctrl (
  input  logic                                AvlClk_i,
  input  logic                                Rstn_i,
  input  logic                                rx_pnd_empty_i,
  input  logic [cpl_pkg::PND_ENTRY_W-1:0]     rx_pnd_dat_i,
  input  logic [2:0]                          dev_csr_mps_i,
  input  logic                                cmd_fifo_busy_i,
  input  logic [3:0]                          cmd_fifo_usedw_i,
  input  logic                                credit_ok_i,
  output logic                                rx_pnd_rdreq_o,
  output logic                                idle_o,
  output logic                                hdr_load_o,
  output logic [cpl_pkg::PND_TAG_W-1:0]       tag_o,
  output logic [cpl_pkg::PND_REQID_W-1:0]     reqid_o,
  output logic [cpl_pkg::PND_ATTR_W-1:0]      attr_o,
  output logic [cpl_pkg::PND_TC_W-1:0]        tc_o,
  output logic [cpl_pkg::PND_ADDR_W-1:0]      addr_o,
  output logic [cpl_pkg::BE_W-1:0]            fbe_o,
  output logic [cpl_pkg::BE_W-1:0]            lbe_o,
  output logic                                hdr_send_o,
  output logic                                first_o,
  output logic [cpl_pkg::BCNT_W-1:0]          remain_bcnt_o,
  output logic [cpl_pkg::BCNT_W-1:0]          send_bcnt_o,
  output logic                                credit_load_o,
  output logic [3:0]                          over_rd_o,
  output logic                                credit_req_o,
  output logic                                credit_send_o
);

  // one-hot state bit positions
  localparam int S_IDLE       = 0;
  localparam int S_FETCH      = 1;
  localparam int S_LOAD       = 2;
  localparam int S_WAIT_DATA  = 3;
  localparam int S_WAIT_FIRST = 4;
  localparam int S_WAIT_MAX   = 5;
  localparam int S_WAIT_LAST  = 6;
  localparam int S_PIPE_FIRST = 7;
  localparam int S_PIPE_MAX   = 8;
  localparam int S_PIPE_LAST  = 9;
  localparam int S_SEND       = 10;
  localparam int S_DONE       = 11;
  localparam int NUM_STATES   = 12;

  logic [NUM_STATES-1:0]          state_q;
  logic [NUM_STATES-1:0]          state_nxt;
  logic [cpl_pkg::PND_DWLEN_W-1:0] dwlen;
  logic [cpl_pkg::BCNT_W-1:0]     owed_q;
  logic [cpl_pkg::BCNT_W-1:0]     to_rcb_q;
  logic [cpl_pkg::BCNT_W-1:0]     mps_q;
  logic [cpl_pkg::BCNT_W-1:0]     send_bytes_q;
  logic                           first_q;
  logic                           cmd_fifo_ok;
  logic                           in_pipe;
  logic                           split_first;
  logic                           split_max;

  // entry fields, valid while in the load state
  assign dwlen   = rx_pnd_dat_i[cpl_pkg::PND_DWLEN_LSB +: cpl_pkg::PND_DWLEN_W];
  assign tag_o   = rx_pnd_dat_i[cpl_pkg::PND_TAG_LSB +: cpl_pkg::PND_TAG_W];
  assign reqid_o = rx_pnd_dat_i[cpl_pkg::PND_REQID_LSB +: cpl_pkg::PND_REQID_W];
  assign attr_o  = rx_pnd_dat_i[cpl_pkg::PND_ATTR_LSB +: cpl_pkg::PND_ATTR_W];
  assign tc_o    = rx_pnd_dat_i[cpl_pkg::PND_TC_LSB +: cpl_pkg::PND_TC_W];
  assign addr_o  = rx_pnd_dat_i[cpl_pkg::PND_ADDR_LSB +: cpl_pkg::PND_ADDR_W];
  assign fbe_o   = rx_pnd_dat_i[cpl_pkg::PND_FBE_LSB +: cpl_pkg::BE_W];
  assign lbe_o   = rx_pnd_dat_i[cpl_pkg::PND_LBE_LSB +: cpl_pkg::BE_W];

  // avalon reads are 64-bit, so odd dword counts or a dword-4 start pull extra bytes
  assign over_rd_o = dwlen[0] ? 4'd4 : (addr_o[0] ? 4'd8 : 4'd0);

  assign cmd_fifo_ok = ~cmd_fifo_busy_i && (cmd_fifo_usedw_i < cpl_pkg::CMD_FIFO_LIMIT);
  assign in_pipe     = state_q[S_PIPE_FIRST] | state_q[S_PIPE_MAX] | state_q[S_PIPE_LAST];

  // split decision for the next completion
  assign split_first = first_q && (owed_q > to_rcb_q);
  assign split_max   = ~first_q && (owed_q > mps_q);

  always_comb
  begin
    state_nxt = '0;
    unique case (1'b1)
      state_q[S_IDLE]:
        state_nxt[rx_pnd_empty_i ? S_IDLE : S_FETCH] = 1'b1;
      state_q[S_FETCH]:
        state_nxt[S_LOAD] = 1'b1;
      state_q[S_LOAD]:
        state_nxt[S_WAIT_DATA] = 1'b1;
      state_q[S_WAIT_DATA]:
        if (!cmd_fifo_ok)
          state_nxt[S_WAIT_DATA] = 1'b1;
        else if (split_first)
          state_nxt[S_WAIT_FIRST] = 1'b1;
        else if (split_max)
          state_nxt[S_WAIT_MAX] = 1'b1;
        else
          state_nxt[S_WAIT_LAST] = 1'b1;
      state_q[S_WAIT_FIRST]:
        state_nxt[S_PIPE_FIRST] = 1'b1;
      state_q[S_WAIT_MAX]:
        state_nxt[S_PIPE_MAX] = 1'b1;
      state_q[S_WAIT_LAST]:
        state_nxt[S_PIPE_LAST] = 1'b1;
      state_q[S_PIPE_FIRST]:
        state_nxt[hdr_send_o ? S_SEND : S_PIPE_FIRST] = 1'b1;
      state_q[S_PIPE_MAX]:
        state_nxt[hdr_send_o ? S_SEND : S_PIPE_MAX] = 1'b1;
      state_q[S_PIPE_LAST]:
        state_nxt[hdr_send_o ? S_SEND : S_PIPE_LAST] = 1'b1;
      // owed count already reduced by the completion just sent
      state_q[S_SEND]:
        state_nxt[(owed_q == '0) ? S_DONE : S_WAIT_DATA] = 1'b1;
      default:
        state_nxt[S_IDLE] = 1'b1;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q <= NUM_STATES'(1) << S_IDLE;
      first_q <= 1'b0;
      owed_q  <= '0;
    end
    else
    begin
      state_q <= state_nxt;
      if (hdr_load_o)
      begin
        first_q <= 1'b1;
        owed_q  <= {dwlen, 2'b00};
      end
      else if (hdr_send_o)
      begin
        first_q <= 1'b0;
        owed_q  <= owed_q - send_bytes_q;
      end
    end
  end

  // request sizing, held for the whole split
  always_ff @(posedge AvlClk_i)
  begin
    if (hdr_load_o)
    begin
      to_rcb_q <= cpl_pkg::BCNT_W'(cpl_pkg::RCB_BYTES) - cpl_pkg::BCNT_W'({addr_o, 2'b00});
      mps_q    <= (dev_csr_mps_i == 3'b000) ? cpl_pkg::BCNT_W'(cpl_pkg::MPS_SMALL) :
                                              cpl_pkg::BCNT_W'(cpl_pkg::MPS_LARGE);
    end
    if (state_q[S_WAIT_DATA])
      send_bytes_q <= split_first ? to_rcb_q : (split_max ? mps_q : owed_q);
  end

  assign idle_o         = state_q[S_IDLE];
  assign rx_pnd_rdreq_o = state_q[S_FETCH];
  assign hdr_load_o     = state_q[S_LOAD];
  assign credit_load_o  = state_q[S_LOAD];
  assign credit_req_o   = state_q[S_WAIT_FIRST] | state_q[S_WAIT_MAX] | state_q[S_WAIT_LAST];
  // commit only with data covered and room in the command FIFO
  assign hdr_send_o     = in_pipe & credit_ok_i & cmd_fifo_ok;
  assign credit_send_o  = hdr_send_o;
  assign first_o        = first_q;
  assign remain_bcnt_o  = owed_q;
  assign send_bcnt_o    = send_bytes_q;

  a_state_onehot: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    $onehot(state_q));

  // credit_ok is registered, so a send never follows a credit request directly
  a_send_after_wait: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    credit_req_o |=> !hdr_send_o);

endmodule

// File: logic/cpl_credit_track.sv
// tracks returned avalon bytes against bytes committed to completions
// counters wrap at 2^CREDIT_W, so outstanding data must stay within the credit window
`timescale 1ns/1ps

module cpl_credit_track #(
  parameter int CPL_BUFF_ADDR_WIDTH = 9
) (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  input  logic                            rd_data_valid_i,
  input  logic                            credit_load_i,
  input  logic [3:0]                      over_rd_i,
  input  logic                            credit_req_i,
  input  logic                            credit_send_i,
  input  logic [cpl_pkg::BCNT_W-1:0]      bytes_i,
  output logic                            credit_ok_o,
  output logic [CPL_BUFF_ADDR_WIDTH-1:0]  cpl_ram_wr_addr_o
);

  logic [cpl_pkg::CREDIT_W-1:0]  limit_q;
  logic [cpl_pkg::CREDIT_W-1:0]  consumed_q;
  logic [cpl_pkg::CREDIT_W-1:0]  required_q;
  logic [cpl_pkg::CREDIT_W-1:0]  avail;
  logic                          armed_q;
  logic [CPL_BUFF_ADDR_WIDTH-1:0] addr_q;

  // modular distance of returned data ahead of the requirement
  assign avail = limit_q - required_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      limit_q     <= '0;
      consumed_q  <= '0;
      required_q  <= '0;
      armed_q     <= 1'b0;
      credit_ok_o <= 1'b0;
      addr_q      <= '0;
    end
    else
    begin
      // one beat is 64 bits of read data
      if (rd_data_valid_i)
      begin
        limit_q <= limit_q + cpl_pkg::CREDIT_W'(cpl_pkg::BEAT_BYTES);
        addr_q  <= addr_q + 1'b1;
      end

      // over-read bytes are never sent, so they count as consumed up front
      if (credit_load_i)
        consumed_q <= consumed_q + cpl_pkg::CREDIT_W'(over_rd_i);
      else if (credit_send_i)
        consumed_q <= consumed_q + bytes_i[cpl_pkg::CREDIT_W-1:0];

      if (credit_req_i)
        required_q <= consumed_q + bytes_i[cpl_pkg::CREDIT_W-1:0];

      if (credit_req_i)
        armed_q <= 1'b1;
      else if (credit_send_i)
        armed_q <= 1'b0;

      // compare one cycle after the requirement settles
      if (credit_req_i || credit_send_i)
        credit_ok_o <= 1'b0;
      else
        credit_ok_o <= armed_q && (avail <= cpl_pkg::CREDIT_W'(cpl_pkg::CREDIT_WINDOW));
    end
  end

  assign cpl_ram_wr_addr_o = addr_q;

  a_send_after_ok: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    credit_send_i |-> credit_ok_o && armed_q);

endmodule

// File: logic/cpl_hdr_build.sv
// builds the 99-bit completion command from the latched request fields
// flush and unsupported-size flag bits stay zero
`timescale 1ns/1ps

module cpl_hdr_build (
  input  logic                             AvlClk_i,
  input  logic                             Rstn_i,
  input  logic                             hdr_load_i,
  input  logic [cpl_pkg::PND_TAG_W-1:0]    tag_i,
  input  logic [cpl_pkg::PND_REQID_W-1:0]  reqid_i,
  input  logic [cpl_pkg::PND_ATTR_W-1:0]   attr_i,
  input  logic [cpl_pkg::PND_TC_W-1:0]     tc_i,
  input  logic [cpl_pkg::PND_ADDR_W-1:0]   addr_i,
  input  logic [cpl_pkg::BE_W-1:0]         fbe_i,
  input  logic [cpl_pkg::BE_W-1:0]         lbe_i,
  input  logic                             hdr_send_i,
  input  logic                             first_i,
  input  logic [cpl_pkg::BCNT_W-1:0]       remain_bcnt_i,
  input  logic [cpl_pkg::BCNT_W-1:0]       send_bcnt_i,
  output logic [cpl_pkg::CMD_W-1:0]        cmd_dat_o,
  output logic                             cmd_wrreq_o
);

  logic [cpl_pkg::PND_TAG_W-1:0]    tag_q;
  logic [cpl_pkg::PND_REQID_W-1:0]  reqid_q;
  logic [cpl_pkg::PND_ATTR_W-1:0]   attr_q;
  logic [cpl_pkg::PND_TC_W-1:0]     tc_q;
  logic [cpl_pkg::BE_W-1:0]         fbe_q;
  logic [cpl_pkg::BE_W-1:0]         lbe_q;
  logic [cpl_pkg::CMD_LA_W-1:0]     la_q;
  logic [1:0]                       fbe_pos;
  logic [1:0]                       fbe_trim;
  logic [1:0]                       lbe_trim;
  logic [cpl_pkg::BCNT_W-1:0]       bcnt;
  logic [cpl_pkg::CMD_W-1:0]        cmd;

  // byte offset of the lowest enabled byte in the first dword
  always_comb
  begin
    if (fbe_i[0])
      fbe_pos = 2'd0;
    else if (fbe_i[1])
      fbe_pos = 2'd1;
    else if (fbe_i[2])
      fbe_pos = 2'd2;
    else if (fbe_i[3])
      fbe_pos = 2'd3;
    else
      fbe_pos = 2'd0;
  end

  // disabled low bytes of the first dword, first completion only
  always_comb
  begin
    casez (fbe_q)
      4'b???1: fbe_trim = 2'd0;
      4'b??10: fbe_trim = 2'd1;
      4'b?100: fbe_trim = 2'd2;
      4'b1000: fbe_trim = 2'd3;
      default: fbe_trim = 2'd0;
    endcase
  end

  // disabled high bytes of the last dword
  always_comb
  begin
    case (lbe_q)
      4'b0111: lbe_trim = 2'd1;
      4'b0011: lbe_trim = 2'd2;
      4'b0001: lbe_trim = 2'd3;
      default: lbe_trim = 2'd0;
    endcase
  end

  assign bcnt = remain_bcnt_i - (first_i ? cpl_pkg::BCNT_W'(fbe_trim) : '0)
              - cpl_pkg::BCNT_W'(lbe_trim);

  always_comb
  begin
    cmd = '0;
    cmd[cpl_pkg::CMD_LA_LSB +: cpl_pkg::CMD_LA_W]         = first_i ? la_q : '0;
    cmd[cpl_pkg::CMD_TAG_LSB +: cpl_pkg::PND_TAG_W]       = tag_q;
    cmd[cpl_pkg::CMD_REQID_LSB +: cpl_pkg::PND_REQID_W]   = reqid_q;
    cmd[cpl_pkg::CMD_ONE_BIT]                             = 1'b1;
    cmd[cpl_pkg::CMD_BCNT_LSB +: cpl_pkg::CMD_BCNT_W]     = bcnt[cpl_pkg::CMD_BCNT_W-1:0];
    cmd[cpl_pkg::CMD_TC_LSB +: cpl_pkg::PND_TC_W]         = tc_q;
    // payload in dwords
    cmd[cpl_pkg::CMD_DWLEN_LSB +: cpl_pkg::CMD_DWLEN_W]   = send_bcnt_i[10:2];
    cmd[cpl_pkg::CMD_ATTR_LSB +: cpl_pkg::PND_ATTR_W]     = attr_q;
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (hdr_load_i)
    begin
      tag_q   <= tag_i;
      reqid_q <= reqid_i;
      attr_q  <= attr_i;
      tc_q    <= tc_i;
      fbe_q   <= fbe_i;
      lbe_q   <= lbe_i;
      la_q    <= {addr_i, fbe_pos};
    end
    if (hdr_send_i)
      cmd_dat_o <= cmd;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cmd_wrreq_o <= 1'b0;
    else
      cmd_wrreq_o <= hdr_send_i;
  end

endmodule

// File: logic/cpl_tx_resp.sv
// transmit completion splitter top level
// only DevCsr_i bits 7..5 (max payload) are used
`timescale 1ns/1ps

module cpl_tx_resp #(
  parameter int CPL_BUFF_ADDR_WIDTH = 9
) (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  input  logic                            RxPndgRdFifoEmpty_i,
  input  logic [cpl_pkg::PND_ENTRY_W-1:0] RxPndgRdFifoDato_i,
  output logic                            RxPndgRdFifoRdReq_o,
  input  logic                            TxReadDataValid_i,
  output logic [cpl_pkg::CMD_W-1:0]       CmdFifoDatin_o,
  output logic                            CmdFifoWrReq_o,
  input  logic [3:0]                      CmdFifoUsedw_i,
  input  logic                            CmdFifoBusy_i,
  output logic [CPL_BUFF_ADDR_WIDTH-1:0]  CplRamWrAddr_o,
  input  logic [31:0]                     DevCsr_i,
  output logic                            TxRespIdle_o
);

  logic                              sm_idle;
  logic                              hdr_load;
  logic [cpl_pkg::PND_TAG_W-1:0]     tag;
  logic [cpl_pkg::PND_REQID_W-1:0]   reqid;
  logic [cpl_pkg::PND_ATTR_W-1:0]    attr;
  logic [cpl_pkg::PND_TC_W-1:0]      tc;
  logic [cpl_pkg::PND_ADDR_W-1:0]    addr;
  logic [cpl_pkg::BE_W-1:0]          fbe;
  logic [cpl_pkg::BE_W-1:0]          lbe;
  logic                              hdr_send;
  logic                              first;
  logic [cpl_pkg::BCNT_W-1:0]        remain_bcnt;
  logic [cpl_pkg::BCNT_W-1:0]        send_bcnt;
  logic                              credit_load;
  logic [3:0]                        over_rd;
  logic                              credit_req;
  logic                              credit_send;
  logic                              credit_ok;

  cpl_split_ctrl split_ctrl_inst (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .rx_pnd_empty_i   (RxPndgRdFifoEmpty_i),
    .rx_pnd_dat_i     (RxPndgRdFifoDato_i),
    .dev_csr_mps_i    (DevCsr_i[7:5]),
    .cmd_fifo_busy_i  (CmdFifoBusy_i),
    .cmd_fifo_usedw_i (CmdFifoUsedw_i),
    .credit_ok_i      (credit_ok),
    .rx_pnd_rdreq_o   (RxPndgRdFifoRdReq_o),
    .idle_o           (sm_idle),
    .hdr_load_o       (hdr_load),
    .tag_o            (tag),
    .reqid_o          (reqid),
    .attr_o           (attr),
    .tc_o             (tc),
    .addr_o           (addr),
    .fbe_o            (fbe),
    .lbe_o            (lbe),
    .hdr_send_o       (hdr_send),
    .first_o          (first),
    .remain_bcnt_o    (remain_bcnt),
    .send_bcnt_o      (send_bcnt),
    .credit_load_o    (credit_load),
    .over_rd_o        (over_rd),
    .credit_req_o     (credit_req),
    .credit_send_o    (credit_send)
  );

  // the same byte count serves both the credit request and the send
  cpl_credit_track #(
    .CPL_BUFF_ADDR_WIDTH (CPL_BUFF_ADDR_WIDTH)
  ) credit_track_inst (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .rd_data_valid_i   (TxReadDataValid_i),
    .credit_load_i     (credit_load),
    .over_rd_i         (over_rd),
    .credit_req_i      (credit_req),
    .credit_send_i     (credit_send),
    .bytes_i           (send_bcnt),
    .credit_ok_o       (credit_ok),
    .cpl_ram_wr_addr_o (CplRamWrAddr_o)
  );

  cpl_hdr_build hdr_build_inst (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .hdr_load_i    (hdr_load),
    .tag_i         (tag),
    .reqid_i       (reqid),
    .attr_i        (attr),
    .tc_i          (tc),
    .addr_i        (addr),
    .fbe_i         (fbe),
    .lbe_i         (lbe),
    .hdr_send_i    (hdr_send),
    .first_i       (first),
    .remain_bcnt_i (remain_bcnt),
    .send_bcnt_i   (send_bcnt),
    .cmd_dat_o     (CmdFifoDatin_o),
    .cmd_wrreq_o   (CmdFifoWrReq_o)
  );

  // idle only with nothing pending upstream
  assign TxRespIdle_o = sm_idle & RxPndgRdFifoEmpty_i;

endmodule

// File: dv/cpl_tx_resp_tb_model.svh
// expected completion commands built from the split and trim rules
// included inside the testbench module, fills its expected command queue
`ifndef CPL_TX_RESP_TB_MODEL_SVH
`define CPL_TX_RESP_TB_MODEL_SVH

// disabled bytes below the first enabled one, zero for an empty mask
function automatic int lead_skip(input logic [3:0] be);
  int n;
  n = 0;
  if (be != 4'b0000)
    while (!be[n])
      n++;
  return n;
endfunction

// disabled bytes above the last enabled one
function automatic int tail_skip(input logic [3:0] be);
  case (be)
    4'b0111: return 1;
    4'b0011: return 2;
    4'b0001: return 3;
    default: return 0;
  endcase
endfunction

// extra bytes fetched so the avalon read starts and ends on 8-byte lines
function automatic int over_read(input int addr_dw, input int dwlen);
  int head;
  int tail;
  head = (addr_dw * 4) % 8;
  tail = (addr_dw * 4 + dwlen * 4) % 8;
  return head + ((tail == 0) ? 0 : 8 - tail);
endfunction

task automatic queue_expected(input row_t r);
  int owed;
  int boundary;
  int mps;
  int chunk;
  bit first;
  logic [cpl_pkg::CMD_W-1:0] cmd;
  owed     = r.dwlen * 4;
  boundary = cpl_pkg::RCB_BYTES - r.addr * 4;
  mps      = (r.mps == 3'd0) ? cpl_pkg::MPS_SMALL : cpl_pkg::MPS_LARGE;
  first    = 1'b1;
  while (owed > 0)
  begin
    // first piece stops at the boundary, then max payload, then the rest
    if (first && owed > boundary)
      chunk = boundary;
    else if (!first && owed > mps)
      chunk = mps;
    else
      chunk = owed;
    cmd = '0;
    if (first)
      cmd[cpl_pkg::CMD_LA_LSB +: cpl_pkg::CMD_LA_W] = 7'(r.addr * 4 + lead_skip(r.fbe));
    cmd[cpl_pkg::CMD_TAG_LSB +: cpl_pkg::PND_TAG_W]     = r.tag;
    cmd[cpl_pkg::CMD_REQID_LSB +: cpl_pkg::PND_REQID_W] = r.reqid;
    cmd[cpl_pkg::CMD_ONE_BIT]                           = 1'b1;
    // byte count is what is still owed, less the unused edge bytes
    cmd[cpl_pkg::CMD_BCNT_LSB +: cpl_pkg::CMD_BCNT_W] =
      12'(owed - (first ? lead_skip(r.fbe) : 0) - tail_skip(r.lbe));
    cmd[cpl_pkg::CMD_TC_LSB +: cpl_pkg::PND_TC_W]       = r.tc;
    cmd[cpl_pkg::CMD_DWLEN_LSB +: cpl_pkg::CMD_DWLEN_W] = 9'(chunk / 4);
    cmd[cpl_pkg::CMD_ATTR_LSB +: cpl_pkg::PND_ATTR_W]   = r.attr;
    exp_cmd_q.push_back(cmd);
    owed  = owed - chunk;
    first = 1'b0;
  end
endtask

`endif

// File: dv/cpl_tx_resp_tb.sv
// completion splitter testbench with a request table, FIFO models and an avalon model
// assumes a 512-entry completion buffer; one request is in flight at a time
`timescale 1ns/1ps

module cpl_tx_resp_tb;

  localparam int ADDR_W     = 9;
  localparam int NUM_ROWS   = 8;
  localparam int MAX_CYCLES = 400 * NUM_ROWS;

  // one table row per pending read
  typedef struct packed {
    logic [7:0]  tag;
    logic [15:0] reqid;
    logic [4:0]  addr;
    logic [10:0] dwlen;
    logic [3:0]  fbe;
    logic [3:0]  lbe;
    logic [1:0]  attr;
    logic [2:0]  tc;
    logic [2:0]  mps;
    logic        stall;
  } row_t;

  logic                            AvlClk_i;
  logic                            Rstn_i;
  logic                            RxPndgRdFifoEmpty_i;
  logic [cpl_pkg::PND_ENTRY_W-1:0] RxPndgRdFifoDato_i;
  logic                            RxPndgRdFifoRdReq_o;
  logic                            TxReadDataValid_i;
  logic [cpl_pkg::CMD_W-1:0]       CmdFifoDatin_o;
  logic                            CmdFifoWrReq_o;
  logic [3:0]                      CmdFifoUsedw_i;
  logic                            CmdFifoBusy_i;
  logic [ADDR_W-1:0]               CplRamWrAddr_o;
  logic [31:0]                     DevCsr_i;
  logic                            TxRespIdle_o;

  logic [cpl_pkg::CMD_W-1:0] exp_cmd_q [$];
  logic [cpl_pkg::CMD_W-1:0] exp_word;
  row_t                      rows [NUM_ROWS];
  int                        cycles = 0;
  int                        total_beats = 0;
  int                        base_beats = 0;
  int                        row_over = 0;
  int                        committed = 0;
  logic                      stall_q = 1'b0;
  logic [31:0]               av_rng = 32'd9;
  logic [31:0]               st_rng = 32'd9;

  cpl_tx_resp #(
    .CPL_BUFF_ADDR_WIDTH (ADDR_W)
  ) cpl_tx_resp_inst (
    .AvlClk_i            (AvlClk_i),
    .Rstn_i              (Rstn_i),
    .RxPndgRdFifoEmpty_i (RxPndgRdFifoEmpty_i),
    .RxPndgRdFifoDato_i  (RxPndgRdFifoDato_i),
    .RxPndgRdFifoRdReq_o (RxPndgRdFifoRdReq_o),
    .TxReadDataValid_i   (TxReadDataValid_i),
    .CmdFifoDatin_o      (CmdFifoDatin_o),
    .CmdFifoWrReq_o      (CmdFifoWrReq_o),
    .CmdFifoUsedw_i      (CmdFifoUsedw_i),
    .CmdFifoBusy_i       (CmdFifoBusy_i),
    .CplRamWrAddr_o      (CplRamWrAddr_o),
    .DevCsr_i            (DevCsr_i),
    .TxRespIdle_o        (TxRespIdle_o)
  );

  `include "cpl_tx_resp_tb_model.svh"

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic cmd_compare(input logic [cpl_pkg::CMD_W-1:0] got,
                             input logic [cpl_pkg::CMD_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t: command got %h expected %h", $time, got, exp));
  endtask

  task automatic addr_compare(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t: buffer address got %0d expected %0d",
                              $time, got, exp));
  endtask

  task automatic cover_compare(input int returned, input int needed);
    if (returned < needed)
      stop_on_error($sformatf("mismatch at %0t: %0d bytes returned, %0d bytes committed",
                              $time, returned, needed));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial
  begin
    AvlClk_i = 1'b0;
    forever #10 AvlClk_i = ~AvlClk_i;
  end

  // cycle limit, beat count and command FIFO state seen by the DUT
  always @(posedge AvlClk_i)
  begin
    cycles  <= cycles + 1;
    stall_q <= CmdFifoBusy_i || (CmdFifoUsedw_i >= cpl_pkg::CMD_FIFO_LIMIT);
    if (TxReadDataValid_i)
      total_beats <= total_beats + 1;
    if (cycles >= MAX_CYCLES)
      stop_on_error($sformatf("timeout, the run did not finish in %0d cycles", MAX_CYCLES));
  end

  // command FIFO write side
  always @(negedge AvlClk_i)
  begin
    if (Rstn_i && CmdFifoWrReq_o)
    begin
      if (stall_q)
        stop_on_error("a command was written while the command FIFO was busy or full");
      else if (exp_cmd_q.size() == 0)
        stop_on_error("a command was written when none was expected");
      else
      begin
        exp_word  = exp_cmd_q.pop_front();
        committed = committed + exp_word[cpl_pkg::CMD_DWLEN_LSB +: cpl_pkg::CMD_DWLEN_W] * 4;
        cover_compare((total_beats - base_beats) * cpl_pkg::BEAT_BYTES, row_over + committed);
        cmd_compare(CmdFifoDatin_o, exp_word);
      end
    end
  end

  // avalon read data, random gaps between beats
  task automatic return_beats(input int n);
    int k;
    int gap;
    for (k = 0; k < n; k++)
    begin
      av_rng = xorshift(av_rng);
      gap    = av_rng % 3;
      repeat (gap) @(negedge AvlClk_i);
      TxReadDataValid_i = 1'b1;
      @(negedge AvlClk_i);
      TxReadDataValid_i = 1'b0;
    end
  endtask

  // busy or nearly full command FIFO until the request is answered
  task automatic stall_cmd_fifo(input logic enable);
    if (enable)
    begin
      while (exp_cmd_q.size() != 0)
      begin
        st_rng         = xorshift(st_rng);
        CmdFifoBusy_i  = (st_rng[1:0] == 2'd0);
        CmdFifoUsedw_i = {st_rng[1:0] == 2'd1, st_rng[6:4]};
        @(negedge AvlClk_i);
      end
      CmdFifoBusy_i  = 1'b0;
      CmdFifoUsedw_i = 4'd0;
    end
  endtask

  task automatic run_row(input row_t r);
    logic [cpl_pkg::PND_ENTRY_W-1:0] entry;
    int waited;
    // ignored bits set so that they show up if decoded
    entry     = '0;
    entry[15] = 1'b1;
    entry[56] = 1'b1;
    entry[cpl_pkg::PND_TAG_LSB +: cpl_pkg::PND_TAG_W]     = r.tag;
    entry[cpl_pkg::PND_ADDR_LSB +: cpl_pkg::PND_ADDR_W]   = r.addr;
    entry[cpl_pkg::PND_REQID_LSB +: cpl_pkg::PND_REQID_W] = r.reqid;
    entry[cpl_pkg::PND_DWLEN_LSB +: cpl_pkg::PND_DWLEN_W] = r.dwlen;
    entry[cpl_pkg::PND_FBE_LSB +: cpl_pkg::BE_W]          = r.fbe;
    entry[cpl_pkg::PND_ATTR_LSB +: cpl_pkg::PND_ATTR_W]   = r.attr;
    entry[cpl_pkg::PND_TC_LSB +: cpl_pkg::PND_TC_W]       = r.tc;
    entry[cpl_pkg::PND_LBE_LSB +: cpl_pkg::BE_W]          = r.lbe;
    queue_expected(r);
    row_over   = over_read(r.addr, r.dwlen);
    base_beats = total_beats;
    committed  = 0;
    @(negedge AvlClk_i);
    DevCsr_i            = {24'h0, r.mps, 5'h0};
    RxPndgRdFifoDato_i  = entry;
    RxPndgRdFifoEmpty_i = 1'b0;
    // non-show-ahead FIFO, entry stays on the bus after the read
    do
      @(negedge AvlClk_i);
    while (!RxPndgRdFifoRdReq_o);
    RxPndgRdFifoEmpty_i = 1'b1;
    fork
      return_beats((r.dwlen * 4 + row_over) / cpl_pkg::BEAT_BYTES);
      stall_cmd_fifo(r.stall);
    join
    while (exp_cmd_q.size() != 0)
      @(negedge AvlClk_i);
    waited = 0;
    while (!TxRespIdle_o && waited < 4)
    begin
      @(negedge AvlClk_i);
      waited++;
    end
    if (!TxRespIdle_o)
      stop_on_error("the idle output stayed low after the last command");
    addr_compare(CplRamWrAddr_o, ADDR_W'(total_beats));
  endtask

  initial
  begin
    int i;
    Rstn_i              = 1'b0;
    RxPndgRdFifoEmpty_i = 1'b1;
    RxPndgRdFifoDato_i  = '0;
    TxReadDataValid_i   = 1'b0;
    CmdFifoUsedw_i      = 4'd0;
    CmdFifoBusy_i       = 1'b0;
    DevCsr_i            = 32'h0;
    // tag, reqid, addr, dwlen, fbe, lbe, attr, tc, mps, stall
    rows[0] = '{8'h11, 16'h1234, 5'd4, 11'd8, 4'hf, 4'hf, 2'd1, 3'd2, 3'd0, 1'b0};
    rows[1] = '{8'h22, 16'hbeef, 5'd3, 11'd5, 4'hc, 4'h3, 2'd2, 3'd5, 3'd1, 1'b0};
    rows[2] = '{8'h33, 16'h0a0b, 5'd8, 11'd100, 4'he, 4'h7, 2'd0, 3'd1, 3'd0, 1'b0};
    rows[3] = '{8'h34, 16'h0a0b, 5'd8, 11'd100, 4'he, 4'h7, 2'd0, 3'd1, 3'd1, 1'b0};
    rows[4] = '{8'h45, 16'hc001, 5'd1, 11'd150, 4'h8, 4'h1, 2'd3, 3'd7, 3'd2, 1'b1};
    rows[5] = '{8'h56, 16'h7f00, 5'd31, 11'd1, 4'h6, 4'h0, 2'd1, 3'd0, 3'd0, 1'b1};
    rows[6] = '{8'h67, 16'h0001, 5'd0, 11'd64, 4'hf, 4'hf, 2'd2, 3'd3, 3'd0, 1'b0};
    // long read that takes the buffer address past its wrap
    rows[7] = '{8'h78, 16'h5a5a, 5'd5, 11'd600, 4'hf, 4'hc, 2'd1, 3'd4, 3'd1, 1'b1};
    repeat (10) @(negedge AvlClk_i);
    Rstn_i = 1'b1;
    @(negedge AvlClk_i);
    if (!TxRespIdle_o || RxPndgRdFifoRdReq_o || CmdFifoWrReq_o)
      stop_on_error("outputs were not at their reset values after reset");
    addr_compare(CplRamWrAddr_o, '0);
    for (i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    if (exp_cmd_q.size() != 0)
      stop_on_error("commands were still expected at the end of the run");
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: cpl_tx_resp.f
+incdir+dv
logic/cpl_pkg.sv
logic/cpl_split_ctrl.sv
logic/cpl_credit_track.sv
logic/cpl_hdr_build.sv
logic/cpl_tx_resp.sv
dv/cpl_tx_resp_tb.sv
